/* design/cmd_analysis_pkg.sv */
`default_nettype none

package cmd_analysis_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////
  localparam int CMD_W             = 128;
  localparam int N_TARGETS         = 8;
  localparam int TGT_W             = $clog2(N_TARGETS);
  localparam int FIFO_DEPTH        = 8;
  localparam int ALMOST_FULL_LEVEL = 6;  // room for one more pair

  ////////////////////////////////////////
  // command field positions
  ////////////////////////////////////////
  localparam int OP_HI     = 127;
  localparam int OP_LO     = 126;
  localparam int TGT_RW_LO = 64;  // read / write target
  localparam int TGT_ER_LO = 0;   // erase target
  localparam int HALF_BIT  = 80;  // half index of a micro command

  typedef logic [CMD_W-1:0]             cmd_t;
  typedef logic [TGT_W-1:0]             target_t;
  typedef logic [$clog2(FIFO_DEPTH):0]  count_t;  // 0 .. FIFO_DEPTH

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_erase = 2'd3  // code 2 unused
  } op_e;

  typedef enum logic [1:0] {
    idle,
    first_half,
    second_half
  } split_state_e;

  typedef struct packed {
    logic    valid;
    target_t target;
    cmd_t    cmd;
  } micro_cmd_t;

endpackage

`default_nettype wire

/* design/target_cmd_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module target_cmd_fifo #(
  parameter int DEPTH = cmd_analysis_pkg::FIFO_DEPTH  // power of two
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  cmd_analysis_pkg::cmd_t din,
  input  logic                   pop,
  output cmd_analysis_pkg::cmd_t dout,
  output logic                   empty,
  output logic                   almost_full
);

  import cmd_analysis_pkg::*;

  localparam int     AW         = $clog2(DEPTH);
  localparam count_t FULL_COUNT = count_t'(DEPTH);
  localparam count_t AF_COUNT   = count_t'(ALMOST_FULL_LEVEL);

  cmd_t          mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  count_t        count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && (count != FULL_COUNT);  // push on full dropped
  assign do_pop  = pop && !empty;                  // pop on empty ignored

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + count_t'(1);
      else if (do_pop && !do_push)
        count <= count - count_t'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  ////////////////////////////////////////
  // head and flags
  ////////////////////////////////////////
  assign dout        = mem[rd_ptr];
  assign empty       = (count == '0);
  assign almost_full = (count >= AF_COUNT);

endmodule

`default_nettype wire

/* design/target_fifo_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module target_fifo_bank (
  input  logic                         clk,
  input  logic                         rst_n,
  input  cmd_analysis_pkg::micro_cmd_t wr_req,
  input  cmd_analysis_pkg::target_t    fifo_addr,
  input  logic                         pop,
  output logic                         fifo_empty,
  output cmd_analysis_pkg::cmd_t       cmd_out,
  output logic                         any_almost_full,
  output logic                         controller_idle
);

  import cmd_analysis_pkg::*;

  logic [N_TARGETS-1:0] push_vec;
  logic [N_TARGETS-1:0] pop_vec;
  logic [N_TARGETS-1:0] empty_vec;
  logic [N_TARGETS-1:0] af_vec;
  cmd_t                 head [N_TARGETS];

  for (genvar i = 0; i < N_TARGETS; i++)
  begin : g_fifo
    // admission already guarded by almost_full, so write unconditionally
    assign push_vec[i] = wr_req.valid && (wr_req.target == target_t'(i));
    assign pop_vec[i]  = pop && (fifo_addr == target_t'(i));

    target_cmd_fifo #(
      .DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .push        (push_vec[i]),
      .din         (wr_req.cmd),
      .pop         (pop_vec[i]),
      .dout        (head[i]),
      .empty       (empty_vec[i]),
      .almost_full (af_vec[i])
    );
  end

  ////////////////////////////////////////
  // scheduler read port, fall-through
  ////////////////////////////////////////
  assign fifo_empty      = empty_vec[fifo_addr];
  assign cmd_out         = head[fifo_addr];
  assign any_almost_full = |af_vec;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      controller_idle <= 1'b0;
    else
      controller_idle <= &empty_vec;  // one cycle behind the fifos
  end

endmodule

`default_nettype wire

/* design/cmd_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  cmd_analysis_pkg::cmd_t    wb_dat_w,
  output logic                      wb_ack,
  input  logic                      any_almost_full,
  input  logic                      split_done,
  output logic                      held,
  output cmd_analysis_pkg::op_e     op,
  output cmd_analysis_pkg::target_t target,
  output cmd_analysis_pkg::cmd_t    cmd
);

  import cmd_analysis_pkg::*;

  logic    ready;
  logic    accept;
  logic    known_op;
  op_e     dec_op;
  target_t dec_target;

  // held covers the whole split, so it also stands for a busy splitter
  assign ready  = !held && !any_almost_full;
  assign accept = wb_cyc && wb_stb && wb_we && ready && !wb_ack;  // no back-to-back ack

  ////////////////////////////////////////
  // operation decode on the bus data
  ////////////////////////////////////////
  always_comb
  begin
    dec_op     = op_read;
    dec_target = wb_dat_w[TGT_RW_LO +: TGT_W];
    known_op   = 1'b1;
    case (wb_dat_w[OP_HI:OP_LO])
      op_read:  dec_op = op_read;
      op_write: dec_op = op_write;
      op_erase:
      begin
        dec_op     = op_erase;
        dec_target = wb_dat_w[TGT_ER_LO +: TGT_W];  // erase keeps target in low bits
      end
      default:  known_op = 1'b0;  // acked, then dropped
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack <= 1'b0;
      held   <= 1'b0;
    end
    else
    begin
      wb_ack <= accept;
      if (accept)
        held <= known_op;
      else if (split_done)
        held <= 1'b0;  // second half written
    end
  end

  // captured command, taken at the ack edge
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd    <= wb_dat_w;
      op     <= dec_op;
      target <= dec_target;
    end
  end

endmodule

`default_nettype wire

/* design/cmd_split_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_split_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         held,
  input  cmd_analysis_pkg::op_e        op,
  input  cmd_analysis_pkg::target_t    target,
  input  cmd_analysis_pkg::cmd_t       cmd,
  output cmd_analysis_pkg::micro_cmd_t wr_req,
  output logic                         split_done
);

  import cmd_analysis_pkg::*;

  split_state_e state;
  split_state_e state_nxt;
  cmd_t         half_cmd;

  ////////////////////////////////////////
  // state register and next state
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= idle;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      idle:
      begin
        if (held)
        begin
          case (op)
            op_read, op_write, op_erase: state_nxt = first_half;
            default:                     state_nxt = idle;
          endcase
        end
      end
      first_half:  state_nxt = second_half;
      second_half: state_nxt = idle;
      default:     state_nxt = idle;
    endcase
  end

  ////////////////////////////////////////
  // micro command output
  ////////////////////////////////////////
  always_comb
  begin
    half_cmd           = cmd;
    half_cmd[HALF_BIT] = (state == second_half);  // 0 first, 1 second
  end

  always_comb
  begin
    wr_req.valid  = (state == first_half) || (state == second_half);
    wr_req.target = target;
    wr_req.cmd    = half_cmd;
  end

  // written at the end of second_half, frees the decoder
  assign split_done = (state == second_half);

endmodule

`default_nettype wire

/* design/cmd_analysis_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_analysis_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // host side, wishbone classic
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  cmd_analysis_pkg::cmd_t    wb_dat_w,
  output logic                      wb_ack,
  // scheduler side
  input  cmd_analysis_pkg::target_t fifo_addr,
  input  logic                      pop,
  output logic                      fifo_empty,
  output cmd_analysis_pkg::cmd_t    cmd_out,
  output logic                      controller_idle
);

  import cmd_analysis_pkg::*;

  logic       held;
  op_e        op;
  target_t    target;
  cmd_t       cmd;
  logic       split_done;
  micro_cmd_t wr_req;
  logic       any_almost_full;

  cmd_decoder u_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_dat_w        (wb_dat_w),
    .wb_ack          (wb_ack),
    .any_almost_full (any_almost_full),
    .split_done      (split_done),
    .held            (held),
    .op              (op),
    .target          (target),
    .cmd             (cmd)
  );

  cmd_split_fsm u_split (
    .clk        (clk),
    .rst_n      (rst_n),
    .held       (held),
    .op         (op),
    .target     (target),
    .cmd        (cmd),
    .wr_req     (wr_req),
    .split_done (split_done)
  );

  target_fifo_bank u_bank (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_req          (wr_req),
    .fifo_addr       (fifo_addr),
    .pop             (pop),
    .fifo_empty      (fifo_empty),
    .cmd_out         (cmd_out),
    .any_almost_full (any_almost_full),
    .controller_idle (controller_idle)
  );

endmodule

`default_nettype wire

/* testbench/cmd_analysis_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_analysis_properties (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         wb_cyc,
  input logic                         wb_stb,
  input logic                         wb_we,
  input logic                         wb_ack,
  input cmd_analysis_pkg::target_t    fifo_addr,
  input logic                         pop,
  input logic                         fifo_empty,
  input cmd_analysis_pkg::cmd_t       cmd_out,
  input cmd_analysis_pkg::micro_cmd_t wr_req
);

  int unsigned fail_count = 0;  // read by the testbench
  logic        push_sel;

  assign push_sel = wr_req.valid && (wr_req.target == fifo_addr);  // push into shown fifo

  a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
  else
  begin
    fail_count++;
    $error("wb_ack held for more than one cycle");
  end

  a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb && wb_we))
  else
  begin
    fail_count++;
    $error("wb_ack without a preceding write strobe");
  end

  a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!fifo_empty && !pop && !push_sel) ##1 $stable(fifo_addr) |-> $stable(cmd_out))
  else
  begin
    fail_count++;
    $error("cmd_out changed with no pop or push");
  end

endmodule

bind cmd_analysis_top cmd_analysis_properties u_props (.*);

`default_nettype wire

/* testbench/tb_cmd_analysis.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cmd_analysis;

  import cmd_analysis_pkg::*;

  localparam int      N_BATCH         = 10;  // random batches of three commands
  localparam int      N_CMDS          = 2 + 2 + 1 + 4 + 3 * N_BATCH;
  localparam int      WATCHDOG_CYCLES = 40 * N_CMDS + 200;
  localparam target_t BP_TGT          = target_t'(5);

  logic    clk;
  logic    rst_n;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  cmd_t    wb_dat_w;
  logic    wb_ack;
  target_t fifo_addr;
  logic    pop;
  logic    fifo_empty;
  cmd_t    cmd_out;
  logic    controller_idle;

  cmd_t    exp_q [N_TARGETS][$];  // expected micro commands per target
  target_t drain_q [$];           // addresses handed to the compare process
  string   cur_test = "none";

  cmd_analysis_top dut0 (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic cmd_t expected_micro(input cmd_t c, input logic half);
    c[HALF_BIT] = half;
    return c;
  endfunction

  function automatic target_t expected_target(input cmd_t c);
    if (c[OP_HI:OP_LO] == 2'd3)
      return c[TGT_ER_LO +: TGT_W];  // erase
    return c[TGT_RW_LO +: TGT_W];
  endfunction

  function automatic cmd_t make_cmd(input logic [1:0] op, input target_t t);
    cmd_t c;
    c = {$urandom(), $urandom(), $urandom(), $urandom()};
    c[OP_HI:OP_LO] = op;
    if (op == 2'd3)
      c[TGT_ER_LO +: TGT_W] = t;
    else
      c[TGT_RW_LO +: TGT_W] = t;
    return c;
  endfunction

  function automatic logic [1:0] pick_op();
    case ($urandom_range(2))
      0:       return 2'd0;
      1:       return 2'd1;
      default: return 2'd3;
    endcase
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_cmd(input string what, input cmd_t exp, input cmd_t act);
    if (act !== exp)
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act));
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act));
  endtask

  task automatic check_target(input string what, input target_t exp, input target_t act);
    if (act !== exp)
      abort_run($sformatf("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act));
  endtask

  ////////////////////////////////////////
  // host and scheduler tasks
  ////////////////////////////////////////
  task automatic start_req(input cmd_t c);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_dat_w <= c;
  endtask

  task automatic wait_ack();
    do
      @(negedge clk);
    while (!wb_ack);
    @(posedge clk);
    wb_cyc <= 1'b0;  // strobe drops after ack
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic send_cmd(input cmd_t c);
    start_req(c);
    wait_ack();
  endtask

  task automatic expect_pair(input cmd_t c);
    exp_q[expected_target(c)].push_back(expected_micro(c, 1'b0));
    exp_q[expected_target(c)].push_back(expected_micro(c, 1'b1));
  endtask

  task automatic pop_check(input target_t a);
    cmd_t exp;
    if (exp_q[a].size() == 0)
      abort_run($sformatf("drain of target %0d with nothing expected there", a));
    exp = exp_q[a].pop_front();
    @(posedge clk);
    fifo_addr <= a;
    pop       <= 1'b0;
    @(negedge clk);
    check_flag("fifo_empty at head", 1'b0, fifo_empty);
    check_cmd("cmd_out", exp, cmd_out);
    @(posedge clk);
    pop <= 1'b1;
    @(posedge clk);
    pop <= 1'b0;
  endtask

  task automatic check_all_empty();
    for (int a = 0; a < N_TARGETS; a++)
    begin
      @(posedge clk);
      fifo_addr <= target_t'(a);
      @(negedge clk);
      check_flag($sformatf("fifo_empty at %0d", a), 1'b1, fifo_empty);
    end
  endtask

  // one command through, checks where it landed, then drains it
  task automatic route_test(input cmd_t c);
    target_t found;
    int      hits;
    found = '0;
    hits  = 0;
    send_cmd(c);
    repeat (4) @(negedge clk);  // 3 cycles to the head, one more for the second half
    for (int a = 0; a < N_TARGETS; a++)
    begin
      @(posedge clk);
      fifo_addr <= target_t'(a);
      @(negedge clk);
      if (!fifo_empty)
      begin
        found = target_t'(a);
        hits++;
      end
    end
    check_flag("single target filled", 1'b1, logic'(hits == 1));
    check_target("route", expected_target(c), found);
    check_flag("controller_idle with entries", 1'b0, controller_idle);
    expect_pair(c);
    drain_q.push_back(found);
    drain_q.push_back(found);
    wait (drain_q.size() == 0);
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////
  initial
  begin : compare
    target_t a;
    forever
    begin
      wait (drain_q.size() != 0);
      a = drain_q[0];
      pop_check(a);
      drain_q.delete(0);
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired, the run did not finish in time");
  end

  initial
  begin : assertion_watch
    wait (dut0.u_props.fail_count != 0);
    abort_run("a bound assertion failed");
  end

  initial
  begin : stimulus
    cmd_t    c;
    target_t t;
    int      rem [N_TARGETS];
    int      left;
    void'($urandom(32'h8f6653ef));
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_dat_w  = '0;
    fifo_addr = '0;
    pop       = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    cur_test = "reset";
    @(negedge clk);
    check_flag("wb_ack", 1'b0, wb_ack);
    @(negedge clk);
    check_flag("controller_idle", 1'b1, controller_idle);
    check_all_empty();

    cur_test = "read_write";
    route_test(make_cmd(2'd0, target_t'(3)));
    route_test(make_cmd(2'd1, target_t'(6)));

    cur_test = "erase";
    route_test(make_cmd(2'd3, target_t'(1)));
    route_test(make_cmd(2'd3, target_t'(7)));

    cur_test = "unknown_op";
    send_cmd(make_cmd(2'd2, target_t'(2)));
    repeat (6)
    begin
      @(negedge clk);
      check_flag("controller_idle", 1'b1, controller_idle);
    end
    check_all_empty();

    cur_test = "backpressure";
    for (int k = 0; k < 3; k++)
    begin
      c = make_cmd(pick_op(), BP_TGT);
      send_cmd(c);
      expect_pair(c);
    end
    repeat (4) @(negedge clk);
    c = make_cmd(2'd1, BP_TGT);
    start_req(c);
    repeat (8)
    begin
      @(negedge clk);
      check_flag("wb_ack while almost full", 1'b0, wb_ack);
    end
    drain_q.push_back(BP_TGT);  // one pop takes it below the level
    wait (drain_q.size() == 0);
    wait_ack();
    expect_pair(c);
    repeat (4) @(negedge clk);
    for (int k = 0; k < 7; k++)
      drain_q.push_back(BP_TGT);
    wait (drain_q.size() == 0);

    cur_test = "random_mix";
    for (int b = 0; b < N_BATCH; b++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        c = make_cmd(pick_op(), target_t'($urandom_range(N_TARGETS - 1)));
        send_cmd(c);
        expect_pair(c);
      end
      repeat (4) @(negedge clk);
      left = 0;
      for (int a = 0; a < N_TARGETS; a++)
      begin
        rem[a] = exp_q[a].size();
        left += rem[a];
      end
      while (left > 0)
      begin
        t = target_t'($urandom_range(N_TARGETS - 1));
        if (rem[t] > 0)
        begin
          rem[t]--;
          left--;
          drain_q.push_back(t);
        end
      end
      wait (drain_q.size() == 0);
    end
    repeat (2) @(negedge clk);
    check_flag("controller_idle after drain", 1'b1, controller_idle);

    if (dut0.u_props.fail_count == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
      abort_run("a bound assertion failed");
  end

endmodule

`default_nettype wire

/* vlog.f */
design/cmd_analysis_pkg.sv
design/target_cmd_fifo.sv
design/target_fifo_bank.sv
design/cmd_decoder.sv
design/cmd_split_fsm.sv
design/cmd_analysis_top.sv
testbench/cmd_analysis_properties.sv
testbench/tb_cmd_analysis.sv

/* Bender.yml */
package:
  name: cmd_analysis

sources:
  - design/cmd_analysis_pkg.sv
  - design/target_cmd_fifo.sv
  - design/target_fifo_bank.sv
  - design/cmd_decoder.sv
  - design/cmd_split_fsm.sv
  - design/cmd_analysis_top.sv
  - target: test
    files:
      - testbench/cmd_analysis_properties.sv
      - testbench/tb_cmd_analysis.sv
